/* logic/mul_pkg.sv */
`default_nettype none

package mul_pkg;

	// *******************************************************************
	// Operand and product widths
	// *******************************************************************

	// Operand width of the execution unit.
	localparam int XLEN = 64;

	// Two extra bits let signed and unsigned operands share one signed array.
	localparam int EXT_W = XLEN + 2;

	// One radix-4 window per two operand bits.
	localparam int PP_NUM = (EXT_W + 1) / 2;

	// Partial products are sign-extended to twice the extended width.
	localparam int PROD_W = 2 * EXT_W;

	// *******************************************************************
	// Wallace column structure
	// *******************************************************************

	// Lateral carries between neighbouring columns, one per full adder.
	localparam int CARRY_W = PP_NUM - 2;

	// Full adder levels for 33 bits: 33-22-15-10-7-5-4-3-2.
	localparam int WT_STAGES = 8;

	// *******************************************************************
	// Pipeline
	// *******************************************************************

	// Accepting edge to the edge that samples out_valid high.
	localparam int MUL_LATENCY = 2;

endpackage

`default_nettype wire

/* logic/booth_partial_product.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_partial_product (
	input  logic [2:0]                  window,
	input  logic [mul_pkg::PROD_W-1:0]  multiplicand_ext,
	output logic [mul_pkg::PROD_W-1:0]  partial,
	output logic                        neg
);

	import mul_pkg::*;

	logic one_x;
	logic two_x;
	logic [PROD_W-1:0] sel;

	// *******************************************************************
	// Radix-4 recoding
	// *******************************************************************
	// 000 111 : 0
	// 001 010 : +1x     101 110 : -1x
	// 011     : +2x     100     : -2x

	assign one_x = window[1] ^ window[0];                    // Middle windows.
	assign two_x = (window == 3'b011) | (window == 3'b100);  // Edge windows.
	assign neg   = window[2] & ~(window[1] & window[0]);     // 111 is plain zero.

	assign sel = ({PROD_W{one_x}} & multiplicand_ext)
		| ({PROD_W{two_x}} & (multiplicand_ext << 1));

	// One's complement only, the +1 enters the tree at bit 0 through neg.
	// Complementing the full shifted word keeps the low bits at one, so a
	// bit-0 increment ripples to the right place.
	assign partial = sel ^ {PROD_W{neg}};

endmodule

`default_nettype wire

/* logic/wallace_column.sv */
`timescale 1ns/1ps
`default_nettype none

module wallace_column (
	input  logic [mul_pkg::PP_NUM-1:0]   bits,
	input  logic [mul_pkg::CARRY_W-1:0]  carry_in,
	output logic [mul_pkg::CARRY_W-1:0]  carry_out,
	output logic                         carry,
	output logic                         sum
);

	import mul_pkg::*;

	// Bits still alive in this column at the input of stage s.
	function automatic int stage_width(input int s);
		int n;
		n = PP_NUM;
		for (int k = 0; k < s; k++) begin
			n = 2 * (n / 3) + n % 3;
		end
		return n;
	endfunction

	// First lateral carry index owned by stage s.
	function automatic int carry_base(input int s);
		int n;
		int b;
		n = PP_NUM;
		b = 0;
		for (int k = 0; k < s; k++) begin
			b = b + n / 3;
			n = 2 * (n / 3) + n % 3;
		end
		return b;
	endfunction

	wire [PP_NUM-1:0] lvl [0:WT_STAGES];

	assign lvl[0] = bits;

	// *******************************************************************
	// Full adder stages
	// *******************************************************************
	// Next level: FA sums, then leftovers, then carries from column i-1.

	for (genvar s = 0; s < WT_STAGES; s++) begin : g_stage
		localparam int N = stage_width(s);
		localparam int F = N / 3;
		localparam int R = N % 3;
		localparam int B = carry_base(s);
		localparam int W = 2 * F + R;

		for (genvar f = 0; f < F; f++) begin : g_fa
			assign lvl[s+1][f] = lvl[s][3*f] ^ lvl[s][3*f+1] ^ lvl[s][3*f+2];
			assign carry_out[B+f] = (lvl[s][3*f] & lvl[s][3*f+1])
				| (lvl[s][3*f] & lvl[s][3*f+2])
				| (lvl[s][3*f+1] & lvl[s][3*f+2]);
		end

		if (R > 0) begin : g_pass
			assign lvl[s+1][F +: R] = lvl[s][3*F +: R];  // Too few for an FA.
		end

		assign lvl[s+1][F+R +: F] = carry_in[B +: F];  // Same stage, one column down.
		assign lvl[s+1][PP_NUM-1:W] = '0;
	end

	// Two bits are left, a half adder gives the outputs.
	assign sum   = lvl[WT_STAGES][0] ^ lvl[WT_STAGES][1];
	assign carry = lvl[WT_STAGES][0] & lvl[WT_STAGES][1];

endmodule

`default_nettype wire

/* logic/booth_wallace_array.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_wallace_array (
	input  logic                          mulw,
	input  logic [1:0]                    mul_signed,
	input  logic [mul_pkg::XLEN-1:0]      multiplicand,
	input  logic [mul_pkg::XLEN-1:0]      multiplier,
	output logic [2*mul_pkg::XLEN-1:0]    product
);

	import mul_pkg::*;

	// Word mode replaces the upper half by copies of bit 31.
	function automatic logic [EXT_W-1:0] extend(
		input logic [XLEN-1:0] op,
		input logic            word,
		input logic            sgn
	);
		logic [XLEN-1:0] base;
		base = word ? {{(XLEN/2){op[XLEN/2-1]}}, op[XLEN/2-1:0]} : op;
		return {{(EXT_W-XLEN){sgn & base[XLEN-1]}}, base};
	endfunction

	logic [EXT_W-1:0]  mcd_ext;
	logic [EXT_W-1:0]  mpr_ext;
	logic [EXT_W:0]    mpr_pad;
	logic [PROD_W-1:0] mcd_wide;
	logic [PROD_W-1:0] raw_sum;

	wire [PROD_W-1:0]  pp [PP_NUM];
	wire [PP_NUM-1:0]  neg;
	wire [PP_NUM-1:0]  col_bits [PROD_W];
	wire [CARRY_W-1:0] lat [PROD_W];
	wire [PROD_W-1:0]  col_sum;
	wire [PROD_W-2:0]  col_carry;

	assign mcd_ext  = extend(multiplicand, mulw, mul_signed[0]);
	assign mpr_ext  = extend(multiplier, mulw, mul_signed[1]);
	assign mpr_pad  = {mpr_ext, 1'b0};                            // Implicit bit -1.
	assign mcd_wide = {{(PROD_W-EXT_W){mcd_ext[EXT_W-1]}}, mcd_ext};

	// *******************************************************************
	// Partial products
	// *******************************************************************

	for (genvar k = 0; k < PP_NUM; k++) begin : g_pp
		booth_partial_product i_pp (
			.window           (mpr_pad[2*k +: 3]),
			.multiplicand_ext (mcd_wide << (2*k)),
			.partial          (pp[k]),
			.neg              (neg[k])
		);
	end

	// *******************************************************************
	// Column compressors
	// *******************************************************************

	assign lat[0] = neg[CARRY_W-1:0];  // Most negate carries ride in column 0.

	for (genvar i = 0; i < PROD_W; i++) begin : g_col
		for (genvar k = 0; k < PP_NUM; k++) begin : g_bit
			assign col_bits[i][k] = pp[k][i];
		end

		if (i == PROD_W - 1) begin : g_last
			// Carries out of the top column fall beyond the product.
			wallace_column i_col (
				.bits      (col_bits[i]),
				.carry_in  (lat[i]),
				.carry_out (),
				.carry     (),
				.sum       (col_sum[i])
			);
		end else begin : g_mid
			wallace_column i_col (
				.bits      (col_bits[i]),
				.carry_in  (lat[i]),
				.carry_out (lat[i+1]),
				.carry     (col_carry[i]),
				.sum       (col_sum[i])
			);
		end
	end

	// Final carry-propagate adder, with the last two negate carries at bit 0.
	assign raw_sum = col_sum + {col_carry, neg[PP_NUM-2]}
		+ {{(PROD_W-1){1'b0}}, neg[PP_NUM-1]};

	assign product = raw_sum[2*XLEN-1:0];

endmodule

`default_nettype wire

/* logic/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mul_valid,
	input  logic                      flush,
	input  logic                      mulw,
	input  logic [1:0]                mul_signed,
	input  logic [mul_pkg::XLEN-1:0]  multiplicand,
	input  logic [mul_pkg::XLEN-1:0]  multiplier,
	output logic                      mul_ready,
	output logic                      out_valid,
	output logic [mul_pkg::XLEN-1:0]  result_hi,
	output logic [mul_pkg::XLEN-1:0]  result_lo
);

	import mul_pkg::*;

	logic                   accept;
	logic [MUL_LATENCY-1:0] valid_q;  // Bit 0 is stage 1, top bit is stage 2.

	logic [XLEN-1:0]        op_a;
	logic [XLEN-1:0]        op_b;
	logic                   op_mulw;
	logic [1:0]             op_signed;
	logic [2*XLEN-1:0]      product;

	assign accept = mul_valid & mul_ready;

	// *******************************************************************
	// Control
	// *******************************************************************
	// A request accepted at edge T is seen with out_valid high at edge
	// T + MUL_LATENCY. A flush at T or T + 1 drops it.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mul_ready <= 1'b0;
			valid_q   <= '0;
		end else begin
			mul_ready <= 1'b1;  // No stall source after reset.
			if (flush) begin
				valid_q <= '0;
			end else begin
				valid_q <= {valid_q[MUL_LATENCY-2:0], accept};
			end
		end
	end

	assign out_valid = valid_q[MUL_LATENCY-1];

	// *******************************************************************
	// Stage 1, operand capture
	// *******************************************************************

	always_ff @(posedge clk) begin
		if (accept) begin
			op_a      <= multiplicand;
			op_b      <= multiplier;
			op_mulw   <= mulw;
			op_signed <= mul_signed;
		end
	end

	booth_wallace_array i_array (
		.mulw         (op_mulw),
		.mul_signed   (op_signed),
		.multiplicand (op_a),
		.multiplier   (op_b),
		.product      (product)
	);

	// *******************************************************************
	// Stage 2, result register
	// *******************************************************************

	always_ff @(posedge clk) begin
		if (valid_q[0]) begin
			result_hi <= product[2*XLEN-1:XLEN];
			result_lo <= product[XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

/* dv/mul_unit_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit_props (
	input logic clk,
	input logic rst_n,
	input logic mul_valid,
	input logic flush,
	input logic mul_ready,
	input logic out_valid
);

	import mul_pkg::*;

	int   fail_count = 0;
	logic accept;

	assign accept = mul_valid & mul_ready;

	// **********************************************************************
	// Pipeline timing and flush
	// **********************************************************************

	latency_check: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && !flush) ##1 !flush |-> ##(MUL_LATENCY-1) out_valid)
	else begin
		fail_count++;
		$error("Accepted request gave no out_valid after %0d cycles.", MUL_LATENCY);
	end

	origin_check: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(accept && !flush, MUL_LATENCY) && !$past(flush))
	else begin
		fail_count++;
		$error("out_valid without a matching unflushed request.");
	end

	flush_check: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (!out_valid) [*MUL_LATENCY])
	else begin
		fail_count++;
		$error("out_valid after a flush.");
	end

	// Reset holds the unit idle; afterwards it never stalls.
	reset_check: assert property (@(posedge clk) !rst_n |=> !mul_ready && !out_valid)
	else begin
		fail_count++;
		$error("mul_ready or out_valid high out of reset.");
	end

	ready_check: assert property (@(posedge clk) rst_n && $past(rst_n) |-> mul_ready)
	else begin
		fail_count++;
		$error("mul_ready dropped outside reset.");
	end

endmodule

`default_nettype wire

/* dv/mul_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;

	import mul_pkg::*;

	localparam int    CLK_PERIOD   = 10;
	localparam int    RESET_CYCLES = 4;
	localparam int    DRAIN_CYCLES = MUL_LATENCY + 1;
	localparam int    MARGIN       = 20;  // Spare cycles past the trace.
	localparam string TRACE_FILE   = "dv/mul_trace.txt";

	logic            clk;
	logic            rst_n;
	logic            mul_valid;
	logic            flush;
	logic            mulw;
	logic [1:0]      mul_signed;
	logic [XLEN-1:0] multiplicand;
	logic [XLEN-1:0] multiplier;
	logic            mul_ready;
	logic            out_valid;
	logic [XLEN-1:0] result_hi;
	logic [XLEN-1:0] result_lo;

	// Trace lines as read from the file.
	bit              tr_valid [$];
	bit              tr_flush [$];
	bit              tr_mulw [$];
	logic [1:0]      tr_signed [$];
	logic [XLEN-1:0] tr_a [$];
	logic [XLEN-1:0] tr_b [$];
	logic [XLEN-1:0] tr_hi [$];
	logic [XLEN-1:0] tr_lo [$];

	// Operations in flight, oldest first.
	logic [XLEN-1:0] exp_hi_q [$];
	logic [XLEN-1:0] exp_lo_q [$];
	int              due_q [$];

	int     cycle = 0;
	int     checks = 0;
	int     value_errors = 0;
	int     protocol_errors = 0;
	int     filler_count = 0;
	int     limit_ns = 0;
	bit     ready_exp = 1'b0;
	bit     loaded = 1'b0;
	integer seed;

	mul_unit i_mul_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	bind mul_unit mul_unit_props i_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mul_ready (mul_ready),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// **********************************************************************
	// Checking
	// **********************************************************************

	task automatic check_value(input string name, input logic [XLEN-1:0] actual,
		input logic [XLEN-1:0] expected);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at cycle %0d",
				name, actual, expected, cycle);
		end
	endtask

	task automatic protocol_error(input string msg);
		protocol_errors++;
		$display("Protocol error at cycle %0d: %s", cycle, msg);
	endtask

	task automatic check_outputs();
		int              due;
		logic [XLEN-1:0] eh;
		logic [XLEN-1:0] el;
		check_value("mul_ready", mul_ready, ready_exp);
		if (out_valid === 1'b1) begin
			if (due_q.size() == 0) begin
				protocol_error("out_valid is high but no operation is in flight.");
			end else begin
				due = due_q.pop_front();
				eh  = exp_hi_q.pop_front();
				el  = exp_lo_q.pop_front();
				if (due != cycle)
					protocol_error($sformatf("result due at cycle %0d came early.", due));
				check_value("result_hi", result_hi, eh);
				check_value("result_lo", result_lo, el);
			end
		end else if (out_valid !== 1'b0) begin
			protocol_error("out_valid is unknown.");
		end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
			protocol_error("an expected result never showed out_valid.");
			void'(due_q.pop_front());
			void'(exp_hi_q.pop_front());
			void'(exp_lo_q.pop_front());
		end
	endtask

	// **********************************************************************
	// Stimulus
	// **********************************************************************

	task automatic drive_step(input bit v, input bit f, input bit w, input logic [1:0] s,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] h, input logic [XLEN-1:0] l);
		@(negedge clk);
		check_outputs();
		mul_valid    = v;
		flush        = f;
		mulw         = w;
		mul_signed   = s;
		multiplicand = a;
		multiplier   = b;
		if (f) begin
			// Also drops the request that is accepted on the same edge.
			while (due_q.size() > 0 && due_q[due_q.size()-1] <= cycle + MUL_LATENCY) begin
				void'(due_q.pop_back());
				void'(exp_hi_q.pop_back());
				void'(exp_lo_q.pop_back());
			end
		end else if (v && ready_exp) begin
			exp_hi_q.push_back(h);
			exp_lo_q.push_back(l);
			due_q.push_back(cycle + MUL_LATENCY);
		end
	endtask

	task automatic filler_step();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [1:0]      s;
		a = {$random(seed), $random(seed)};
		b = {$random(seed), $random(seed)};
		s = $random(seed);
		drive_step(1'b0, 1'b0, a[7], s, a, b, '0, '0);  // Idle, must give no output.
	endtask

	task automatic load_trace(output bit ok);
		int              fd;
		string           line;
		logic [3:0]      v;
		logic [3:0]      f;
		logic [3:0]      w;
		logic [3:0]      s;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] h;
		logic [XLEN-1:0] l;
		ok = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line.getc(0) != "#" &&
					$sscanf(line, "%h %h %h %h %h %h %h %h", v, f, w, s, a, b, h, l) == 8) begin
					tr_valid.push_back(v[0]);
					tr_flush.push_back(f[0]);
					tr_mulw.push_back(w[0]);
					tr_signed.push_back(s[1:0]);
					tr_a.push_back(a);
					tr_b.push_back(b);
					tr_hi.push_back(h);
					tr_lo.push_back(l);
					if (!v[0] && !f[0])
						filler_count++;
				end
			end
			$fclose(fd);
			ok = (tr_valid.size() > 0);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		@(posedge clk);
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("mul_ready", mul_ready, '0);
			check_value("out_valid", out_valid, '0);
		end
		rst_n     = 1'b1;
		ready_exp = 1'b1;  // Ready from the first edge out of reset.
	endtask

	// **********************************************************************
	// Main sequence and watchdog
	// **********************************************************************

	initial begin
		bit ok;
		int i;
		int total_errors;
		rst_n        = 1'b0;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		mulw         = 1'b0;
		mul_signed   = 2'b00;
		multiplicand = '0;
		multiplier   = '0;
		seed         = 32'hef0bf870;
		load_trace(ok);
		if (!ok) begin
			$display("Could not read any operation from %s.", TRACE_FILE);
			$display("Finished with errors");
			$finish;
		end else begin
			limit_ns = (RESET_CYCLES + tr_valid.size() + filler_count + MARGIN) * CLK_PERIOD;
			loaded   = 1'b1;
			apply_reset();
			for (i = 0; i < tr_valid.size(); i++) begin
				drive_step(tr_valid[i], tr_flush[i], tr_mulw[i], tr_signed[i],
					tr_a[i], tr_b[i], tr_hi[i], tr_lo[i]);
				if (!tr_valid[i] && !tr_flush[i])
					filler_step();
			end
			repeat (DRAIN_CYCLES) drive_step(1'b0, 1'b0, 1'b0, 2'b00, '0, '0, '0, '0);
			if (due_q.size() > 0)
				protocol_error($sformatf("%0d results never appeared.", due_q.size()));
			total_errors = value_errors + protocol_errors + i_mul_unit.i_props.fail_count;
			$display("Checks: %0d, value errors: %0d, protocol errors: %0d, %s %0d",
				checks, value_errors, protocol_errors, "assertion failures:",
				i_mul_unit.i_props.fail_count);
			if (total_errors == 0) begin
				$display("Finished with no errors");
			end else begin
				$display("Finished with errors");
			end
			$finish;
		end
	end

	initial begin
		wait (loaded);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the run did not complete.", limit_ns);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/mul_trace.txt */
# Columns in hex: mul_valid flush mulw mul_signed multiplicand multiplier expected_hi expected_lo
# mul_signed bit 0 marks the multiplicand signed, bit 1 the multiplier signed.
1 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 0000000000000001
1 0 0 0 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 0000000000000002 0000000000000003 0000000000000000 0000000000000006
1 0 0 0 123456789ABCDEF0 0000000000000001 0000000000000000 123456789ABCDEF0
1 0 0 0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
1 0 0 0 FFFFFFFFFFFFFFFF 0000000000000002 0000000000000001 FFFFFFFFFFFFFFFE
1 0 0 0 0000000100000000 0000000100000000 0000000000000001 0000000000000000
1 0 0 0 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000000 FFFFFFFE00000001
1 0 0 0 AAAAAAAAAAAAAAAA 0000000000000003 0000000000000001 FFFFFFFFFFFFFFFE
1 0 0 0 5555555555555555 0000000000000003 0000000000000000 FFFFFFFFFFFFFFFF
1 0 0 0 0000000000010000 0000000000010000 0000000000000000 0000000100000000
1 0 0 0 1000000000000000 0000000000000010 0000000000000001 0000000000000000
1 0 0 0 FFFFFFFFFFFFFFFF 8000000000000000 7FFFFFFFFFFFFFFF 8000000000000000
1 0 0 0 0123456789ABCDEF 0000000000000100 0000000000000001 23456789ABCDEF00
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 3 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000 0000000000000001
1 0 0 3 8000000000000000 8000000000000000 4000000000000000 0000000000000000
1 0 0 3 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 8000000000000000
1 0 0 3 8000000000000000 0000000000000001 FFFFFFFFFFFFFFFF 8000000000000000
1 0 0 3 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFA
1 0 0 3 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 3FFFFFFFFFFFFFFF 0000000000000001
1 0 0 3 7FFFFFFFFFFFFFFF 8000000000000000 C000000000000000 8000000000000000
1 0 0 3 AAAAAAAAAAAAAAAA 0000000000000003 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFE
1 0 0 3 FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 8000000000000001
1 0 0 3 0000000000000000 8000000000000000 0000000000000000 0000000000000000
1 0 0 3 FFFFFFFF00000000 0000000100000000 FFFFFFFFFFFFFFFF 0000000000000000
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
1 0 0 1 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 8000000000000000
1 0 0 1 0000000000000002 8000000000000000 0000000000000001 0000000000000000
1 0 0 1 FFFFFFFFFFFFFFFE 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
1 0 0 2 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
1 0 0 2 8000000000000000 8000000000000000 C000000000000000 0000000000000000
1 0 0 2 0000000000000003 FFFFFFFFFFFFFFFD FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFF7
1 0 0 2 7FFFFFFFFFFFFFFF 0000000000000002 0000000000000000 FFFFFFFFFFFFFFFE
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 1 3 DEADBEEF00000005 1234567800000007 0000000000000000 0000000000000023
1 0 1 3 00000000FFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE
1 0 1 3 1111111180000000 2222222280000000 0000000000000000 4000000000000000
1 0 1 0 00000000FFFFFFFF 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF
1 0 1 0 FFFFFFFF7FFFFFFF 0000000000000002 0000000000000000 00000000FFFFFFFE
1 0 1 3 ABCDEF0100000010 9999999900000100 0000000000000000 0000000000001000
1 0 1 0 0000000080000000 0000000080000000 FFFFFFFF00000000 4000000000000000
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 0000000000000005 0000000000000007 0000000000000000 0000000000000023
1 1 0 0 0000000000000009 0000000000000009 0000000000000000 0000000000000051
1 0 0 0 000000000000000B 000000000000000B 0000000000000000 0000000000000079
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 0000000000000004 0000000000000004 0000000000000000 0000000000000010
0 1 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 FFFFFFFFFFFFFFFF 0000000000000010 000000000000000F FFFFFFFFFFFFFFF0
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 0 0000000000001000 0000000000001000 0000000000000000 0000000001000000
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 1 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
1 0 0 3 FFFFFFFFFFFFFFFF 0000000000000005 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFB
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 0 0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000

/* booth_mul.f */
logic/mul_pkg.sv
logic/booth_partial_product.sv
logic/wallace_column.sv
logic/booth_wallace_array.sv
logic/mul_unit.sv
dv/mul_unit_props.sv
dv/mul_unit_tb.sv

/* Bender.yml */
package:
  name: booth_mul

sources:
  - logic/mul_pkg.sv
  - logic/booth_partial_product.sv
  - logic/wallace_column.sv
  - logic/booth_wallace_array.sv
  - logic/mul_unit.sv
  - target: test
    files:
      - dv/mul_unit_props.sv
      - dv/mul_unit_tb.sv
